// ==== src/fft_buf_pkg.sv ====
package fft_buf_pkg;

  // Bus and storage widths
  localparam int data_w      = 32;  // Stream and AXI-lite data
  localparam int word_w      = 64;  // RAM word, {y, x} in complex modes
  localparam int u_w         = 16;  // Integer sample
  localparam int axil_addr_w = 12;

  // Register map, one register only
  localparam logic [axil_addr_w-1:0] status_addr = '0;  // Done status on read, restart on write

  // Command beat, bits 3:2 must match to start a frame
  localparam logic [1:0] cmd_tag = 2'b01;

  // Transform mode, bit 1 picks the integer path
  typedef enum logic [1:0] {
    mode_fft  = 2'd0,
    mode_ifft = 2'd1,
    mode_ntt  = 2'd2,
    mode_intt = 2'd3
  } mode_e;

  // Frame phases seen by the controller
  typedef enum logic [1:0] {
    ph_cmd,   // Waiting for a command beat
    ph_in,    // Loading the frame
    ph_out,   // Streaming it back
    ph_done   // Complete, waits for restart
  } phase_e;

  // Output stage
  typedef enum logic [2:0] {
    os_idle,
    os_read,     // RAM read in flight
    os_beat_lo,  // x beat
    os_beat_hi,  // y beat
    os_int       // Single integer beat
  } out_state_e;

  // NTT and iNTT share the 16-bit path
  function automatic logic is_int(mode_e m);
    return m[1];
  endfunction

endpackage

// ==== src/ram_if.sv ====
`timescale 1ns/1ps

interface ram_if
  import fft_buf_pkg::*;
#(
  parameter int addr_w = 10
) ();

  logic              en;   // Access this cycle
  logic              we;   // Write when set, read otherwise
  logic [addr_w-1:0] adr;
  logic [word_w-1:0] d;
  logic [word_w-1:0] q;    // Read data, one cycle after en

  // Stage side
  modport master (output en, we, adr, d, input q);

  // Memory side
  modport mem (input en, we, adr, d, output q);

endinterface

// ==== src/axil_status_regs.sv ====
`timescale 1ns/1ps

module axil_status_regs
  import fft_buf_pkg::*;
(
  input  logic                   axi_clk,
  input  logic                   axi_reset_n,
  input  logic                   awvalid,
  input  logic [axil_addr_w-1:0] awaddr,
  input  logic                   wvalid,
  input  logic [data_w-1:0]      wdata,
  output logic                   awready,
  output logic                   wready,
  input  logic                   arvalid,
  input  logic [axil_addr_w-1:0] araddr,
  output logic                   arready,
  output logic                   rvalid,
  output logic [data_w-1:0]      rdata,
  input  logic                   rready,
  input  logic                   done_status,
  output logic                   restart
);

  typedef enum logic {
    rd_idle,
    rd_held   // Address captured, data on the bus
  } rd_state_e;

  rd_state_e              rd_state;
  logic [axil_addr_w-1:0] rd_adr;
  logic                   wr_fire;

  // Write side, address and data taken together in one cycle
  assign wr_fire = awvalid && wvalid;
  assign awready = wr_fire;
  assign wready  = wr_fire;
  assign restart = wr_fire && (awaddr == status_addr) && wdata[0];  // Only bit 0 matters

  // Read side
  assign arready = 1'b1;  // Single outstanding read, a second address is dropped
  assign rvalid  = (rd_state == rd_held);

  always_ff @(posedge axi_clk or negedge axi_reset_n) begin
    if (!axi_reset_n) begin
      rd_state <= rd_idle;
      rd_adr   <= '0;
    end else begin
      case (rd_state)
        rd_idle: if (arvalid) begin
          rd_adr   <= araddr;
          rd_state <= rd_held;
        end
        rd_held: if (rready) rd_state <= rd_idle;  // Data taken
        default: rd_state <= rd_idle;
      endcase
    end
  end

  // Status is live, follows the controller while the read waits
  always_comb begin
    rdata = '0;
    if (rvalid && (rd_adr == status_addr))
      rdata = data_w'(done_status);
  end

endmodule

// ==== src/frame_ctrl.sv ====
`timescale 1ns/1ps

module frame_ctrl
  import fft_buf_pkg::*;
(
  input  logic              axi_clk,
  input  logic              axi_reset_n,
  input  logic              ss_tvalid,
  input  logic [data_w-1:0] ss_tdata,
  input  logic              in_ready,     // Packer can take a beat
  output logic              ss_tready,
  input  logic              load_done,
  input  logic              unload_done,
  input  logic              restart,
  output mode_e             mode,
  output logic              load,
  output logic              unload,
  output logic              done_status
);

  phase_e phase;
  phase_e phase_nxt;
  logic   cmd_beat;

  // Stream slave ready, command beats are always swallowed
  always_comb begin
    case (phase)
      ph_cmd:  ss_tready = 1'b1;
      ph_in:   ss_tready = in_ready;
      default: ss_tready = 1'b0;  // Output pending or done
    endcase
  end

  // Only a tagged beat starts a frame, anything else is dropped
  assign cmd_beat = (phase == ph_cmd) && ss_tvalid && ss_tready
                    && (ss_tdata[3:2] == cmd_tag);

  always_comb begin
    phase_nxt = phase;
    case (phase)
      ph_cmd:  if (cmd_beat) phase_nxt = ph_in;
      ph_in:   if (load_done) phase_nxt = ph_out;
      ph_out:  if (unload_done) phase_nxt = ph_done;
      ph_done: if (restart) phase_nxt = ph_cmd;  // Ignored elsewhere
      default: phase_nxt = ph_cmd;
    endcase
  end

  always_ff @(posedge axi_clk or negedge axi_reset_n) begin
    if (!axi_reset_n) begin
      phase <= ph_cmd;
      mode  <= mode_fft;
    end else begin
      phase <= phase_nxt;
      if (cmd_beat) mode <= mode_e'(ss_tdata[1:0]);  // Held for the whole frame
    end
  end

  // Phase levels to the stages
  assign load        = (phase == ph_in);
  assign unload      = (phase == ph_out);
  assign done_status = (phase == ph_done);

endmodule

// ==== src/stream_in_packer.sv ====
`timescale 1ns/1ps

module stream_in_packer
  import fft_buf_pkg::*;
#(
  parameter int frame_words = 1024
) (
  input  logic              axi_clk,
  input  logic              axi_reset_n,
  input  logic              load,
  input  mode_e             mode,
  input  logic              ss_tvalid,
  input  logic [data_w-1:0] ss_tdata,
  output logic              in_ready,
  output logic              load_done,
  ram_if.master             wr
);

  localparam int addr_w = $clog2(frame_words);
  localparam logic [addr_w-1:0] last_adr = addr_w'(frame_words - 1);

  logic              half;      // x already held, next beat is y
  logic              flush;     // Final word written, frame closed
  logic [data_w-1:0] x_hold;
  logic [addr_w-1:0] adr;
  logic              int_mode;
  logic              beat;
  logic              wr_word;

  assign int_mode = is_int(mode);
  assign in_ready = load && !flush;  // Stalls once the frame is full
  assign beat     = ss_tvalid && in_ready;
  assign wr_word  = beat && (int_mode || half);  // Write on the word's last beat
  assign load_done = load && flush;  // One cycle, load drops right after

  // Write port
  assign wr.en  = wr_word;
  assign wr.we  = wr_word;
  assign wr.adr = adr;
  assign wr.d   = int_mode ? word_w'(ss_tdata[u_w-1:0])  // Low 16 bits only
                           : {ss_tdata, x_hold};         // y high, x low

  always_ff @(posedge axi_clk or negedge axi_reset_n) begin
    if (!axi_reset_n) begin
      half  <= 1'b0;
      flush <= 1'b0;
      adr   <= '0;
    end else if (!load) begin
      half  <= 1'b0;  // Clean start for every frame
      flush <= 1'b0;
      adr   <= '0;
    end else begin
      if (beat && !int_mode) half <= !half;
      if (wr_word) begin
        adr <= adr + 1'b1;
        if (adr == last_adr) flush <= 1'b1;
      end
    end
  end

  // x half of a complex pair
  always_ff @(posedge axi_clk) begin
    if (beat && !int_mode && !half) x_hold <= ss_tdata;
  end

endmodule

// ==== src/frame_ram.sv ====
`timescale 1ns/1ps

module frame_ram
  import fft_buf_pkg::*;
#(
  parameter int frame_words = 1024
) (
  input  logic axi_clk,
  input  logic load,   // Write side owns the array
  ram_if.mem   wr,
  ram_if.mem   rd
);

  localparam int addr_w = $clog2(frame_words);

  logic [word_w-1:0] mem [frame_words];
  logic [word_w-1:0] q;
  logic              en;
  logic              we;
  logic [addr_w-1:0] adr;
  logic [word_w-1:0] d;

  // Single physical port, the loading stage wins
  assign en  = load ? wr.en  : rd.en;
  assign we  = load ? wr.we  : rd.we;
  assign adr = load ? wr.adr : rd.adr;
  assign d   = load ? wr.d   : rd.d;

  always_ff @(posedge axi_clk) begin
    if (en) begin
      if (we) mem[adr] <= d;
      else q <= mem[adr];  // Held until the next read
    end
  end

  assign wr.q = q;
  assign rd.q = q;

endmodule

// ==== src/stream_out_unpacker.sv ====
`timescale 1ns/1ps

module stream_out_unpacker
  import fft_buf_pkg::*;
#(
  parameter int frame_words = 1024
) (
  input  logic              axi_clk,
  input  logic              axi_reset_n,
  input  logic              unload,
  input  mode_e             mode,
  input  logic              sm_tready,
  output logic              sm_tvalid,
  output logic [data_w-1:0] sm_tdata,
  output logic              sm_tlast,
  output logic              unload_done,
  ram_if.master             rd
);

  localparam int addr_w = $clog2(frame_words);
  localparam logic [addr_w-1:0] last_adr = addr_w'(frame_words - 1);

  out_state_e        state;
  out_state_e        state_nxt;
  logic [addr_w-1:0] adr;
  logic              last_word;
  logic              word_end;  // Final beat of a word accepted

  assign last_word = (adr == last_adr);
  assign word_end  = sm_tready && ((state == os_beat_hi) || (state == os_int));

  // Read only port
  assign rd.en  = (state == os_read);
  assign rd.we  = 1'b0;
  assign rd.d   = '0;
  assign rd.adr = adr;

  always_comb begin
    state_nxt = state;
    case (state)
      os_idle:    if (unload) state_nxt = os_read;
      os_read:    state_nxt = is_int(mode) ? os_int : os_beat_lo;
      os_beat_lo: if (sm_tready) state_nxt = os_beat_hi;
      os_beat_hi,
      os_int:     if (sm_tready) state_nxt = last_word ? os_idle : os_read;
      default:    state_nxt = os_idle;
    endcase
  end

  always_ff @(posedge axi_clk or negedge axi_reset_n) begin
    if (!axi_reset_n) begin
      state <= os_idle;
      adr   <= '0;
    end else begin
      state <= state_nxt;
      if (!unload) adr <= '0;
      else if (word_end) adr <= last_word ? '0 : adr + 1'b1;  // Next word
    end
  end

  // Beats come straight off the RAM output register, stable under stall
  assign sm_tvalid = (state == os_beat_lo) || (state == os_beat_hi) || (state == os_int);

  always_comb begin
    case (state)
      os_beat_lo: sm_tdata = rd.q[data_w-1:0];         // x
      os_beat_hi: sm_tdata = rd.q[word_w-1:data_w];    // y
      os_int:     sm_tdata = data_w'(rd.q[u_w-1:0]);  // Zero-extended u
      default:    sm_tdata = '0;
    endcase
  end

  assign sm_tlast    = last_word && ((state == os_beat_hi) || (state == os_int));
  assign unload_done = sm_tlast && sm_tready;

endmodule

// ==== src/fft_buf_top.sv ====
`timescale 1ns/1ps

module fft_buf_top
  import fft_buf_pkg::*;
#(
  parameter int frame_words = 1024
) (
  input  logic                   axi_clk,
  input  logic                   axi_reset_n,
  // AXI-lite
  input  logic                   awvalid,
  input  logic [axil_addr_w-1:0] awaddr,
  input  logic                   wvalid,
  input  logic [data_w-1:0]      wdata,
  output logic                   awready,
  output logic                   wready,
  input  logic                   arvalid,
  input  logic [axil_addr_w-1:0] araddr,
  output logic                   arready,
  output logic                   rvalid,
  output logic [data_w-1:0]      rdata,
  input  logic                   rready,
  // Stream slave
  input  logic                   ss_tvalid,
  input  logic [data_w-1:0]      ss_tdata,
  input  logic                   ss_tlast,   // Frame length is fixed, not used
  output logic                   ss_tready,
  // Stream master
  output logic                   sm_tvalid,
  output logic [data_w-1:0]      sm_tdata,
  output logic                   sm_tlast,
  input  logic                   sm_tready
);

  localparam int addr_w = $clog2(frame_words);

  mode_e mode;
  logic  load;
  logic  unload;
  logic  load_done;
  logic  unload_done;
  logic  in_ready;
  logic  done_status;
  logic  restart;

  ram_if #(.addr_w(addr_w)) wr_port ();
  ram_if #(.addr_w(addr_w)) rd_port ();

  axil_status_regs axil_status_regs_i (
    .axi_clk, .axi_reset_n,
    .awvalid, .awaddr, .wvalid, .wdata, .awready, .wready,
    .arvalid, .araddr, .arready, .rvalid, .rdata, .rready,
    .done_status,
    .restart
  );

  frame_ctrl frame_ctrl_i (
    .axi_clk, .axi_reset_n,
    .ss_tvalid, .ss_tdata, .in_ready, .ss_tready,
    .load_done, .unload_done, .restart,
    .mode, .load, .unload, .done_status
  );

  stream_in_packer #(.frame_words(frame_words)) stream_in_packer_i (
    .axi_clk, .axi_reset_n,
    .load, .mode, .ss_tvalid, .ss_tdata,
    .in_ready, .load_done,
    .wr (wr_port.master)
  );

  frame_ram #(.frame_words(frame_words)) frame_ram_i (
    .axi_clk,
    .load,
    .wr (wr_port.mem),
    .rd (rd_port.mem)
  );

  stream_out_unpacker #(.frame_words(frame_words)) stream_out_unpacker_i (
    .axi_clk, .axi_reset_n,
    .unload, .mode, .sm_tready,
    .sm_tvalid, .sm_tdata, .sm_tlast, .unload_done,
    .rd (rd_port.master)
  );

endmodule

// ==== sim/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int period       = 20,  // ns
  parameter int reset_cycles = 3
) (
  output logic axi_clk,
  output logic axi_reset_n
);

  initial begin
    axi_clk = 1'b0;
    forever #(period / 2) axi_clk = ~axi_clk;
  end

  initial begin
    axi_reset_n = 1'b0;
    repeat (reset_cycles) @(posedge axi_clk);
    #2 axi_reset_n = 1'b1;  // Off the edge, same as stimulus
  end

endmodule

// ==== sim/tb_tasks.svh ====
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// Every task starts and ends drive_dly after a rising edge
// Outputs are sampled on the falling edge away from updates

// Value compare that stops the run on a mismatch
task automatic check(input string name, input logic [data_w-1:0] got,
                     input logic [data_w-1:0] exp);
  if (got !== exp) begin
    $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
    abort_run();
  end
endtask

// One stream slave beat that waits out a low ss_tready
task automatic send_beat(input logic [data_w-1:0] data);
  ss_tvalid = 1'b1;
  ss_tdata  = data;
  @(negedge axi_clk);
  while (!ss_tready) @(negedge axi_clk);
  @(posedge axi_clk);  // Beat taken here
  #drive_dly;
  ss_tvalid = 1'b0;
endtask

// Address and data together with ready in the same cycle
task automatic axil_write(input logic [axil_addr_w-1:0] addr, input logic [data_w-1:0] data);
  awvalid = 1'b1;
  wvalid  = 1'b1;
  awaddr  = addr;
  wdata   = data;
  @(negedge axi_clk);
  check("awready", 32'(awready), 32'd1);
  check("wready", 32'(wready), 32'd1);
  @(posedge axi_clk);
  #drive_dly;
  awvalid = 1'b0;
  wvalid  = 1'b0;
endtask

task automatic axil_read(input logic [axil_addr_w-1:0] addr, output logic [data_w-1:0] data);
  arvalid = 1'b1;
  araddr  = addr;
  rready  = 1'b1;
  @(negedge axi_clk);
  check("arready", 32'(arready), 32'd1);
  @(posedge axi_clk);  // Address taken
  #drive_dly;
  arvalid = 1'b0;
  @(negedge axi_clk);
  check("rvalid", 32'(rvalid), 32'd1);  // One cycle after the address
  data = rdata;
  @(posedge axi_clk);
  #drive_dly;
  rready = 1'b0;
endtask

// One output beat with optional random sm_tready stalls
task automatic collect_beat(input bit stall, output logic [data_w-1:0] data, output bit last);
  logic [31:0]       rnd;
  bit                taken;
  bit                held;
  logic [data_w-1:0] held_data;
  logic              held_last;
  taken     = 1'b0;
  held      = 1'b0;
  held_data = '0;
  held_last = 1'b0;
  while (!taken) begin
    rnd       = $random(seed);
    sm_tready = stall ? rnd[0] : 1'b1;
    @(negedge axi_clk);
    check("ss_tready", 32'(ss_tready), 32'd0);  // Input closed while output pending
    if (held) begin  // Beat stalled last cycle must not move
      check("sm_tvalid", 32'(sm_tvalid), 32'd1);
      check("sm_tdata", sm_tdata, held_data);
      check("sm_tlast", 32'(sm_tlast), 32'(held_last));
    end
    held      = sm_tvalid && !sm_tready;
    held_data = sm_tdata;
    held_last = sm_tlast;
    if (sm_tvalid && sm_tready) begin
      taken = 1'b1;
      data  = sm_tdata;
      last  = sm_tlast;
    end
    @(posedge axi_clk);
    #drive_dly;
  end
  sm_tready = 1'b0;
endtask

`endif

// ==== sim/tb_fft_buf.sv ====
`timescale 1ns/1ps

module tb_fft_buf
  import fft_buf_pkg::*;
();

  localparam int frame_words    = 8;
  localparam int drive_dly      = 2;     // ns after the rising edge
  localparam int timeout_cycles = 4000;  // About 10x the beats of all tests with stalls

  logic                   axi_clk;
  logic                   axi_reset_n;
  logic                   awvalid;
  logic [axil_addr_w-1:0] awaddr;
  logic                   wvalid;
  logic [data_w-1:0]      wdata;
  logic                   awready;
  logic                   wready;
  logic                   arvalid;
  logic [axil_addr_w-1:0] araddr;
  logic                   arready;
  logic                   rvalid;
  logic [data_w-1:0]      rdata;
  logic                   rready;
  logic                   ss_tvalid;
  logic [data_w-1:0]      ss_tdata;
  logic                   ss_tlast;
  logic                   ss_tready;
  logic                   sm_tvalid;
  logic [data_w-1:0]      sm_tdata;
  logic                   sm_tlast;
  logic                   sm_tready;

  int seed;
  int cycle_count = 0;

  tb_clk_gen clk_gen_i (.axi_clk, .axi_reset_n);

  fft_buf_top #(.frame_words(frame_words)) fft_buf_top_i (.*);

  task automatic abort_run();
    $display("SIMULATION FAILED");
    $fatal(1, "Run stopped at the first error");
  endtask

  `include "tb_tasks.svh"

  // Hang guard
  always @(posedge axi_clk) begin
    cycle_count++;
    if (cycle_count > timeout_cycles) begin
      $display("Timeout, the tests did not finish within %0d clock cycles", timeout_cycles);
      abort_run();
    end
  end

  task automatic expect_status(input logic [data_w-1:0] exp);
    logic [data_w-1:0] rd;
    axil_read(status_addr, rd);
    check("rdata", rd, exp);
  endtask

  // No output activity for a few cycles
  task automatic expect_quiet(input int cycles, input logic ss_rdy);
    repeat (cycles) begin
      @(negedge axi_clk);
      check("sm_tvalid", 32'(sm_tvalid), 32'd0);
      check("ss_tready", 32'(ss_tready), 32'(ss_rdy));
    end
    @(posedge axi_clk);
    #drive_dly;
  endtask

  task automatic test_ignored_beats();
    logic [data_w-1:0] data;
    repeat (4) begin
      data = $random(seed);
      if (data[3:2] == cmd_tag) data[3:2] = 2'b11;  // Never a command
      send_beat(data);
    end
    expect_quiet(4, 1'b1);
    expect_status(32'd0);
  endtask

  // x then y per word keeps the output order equal to the input order
  task automatic test_complex_frame(input mode_e m);
    logic [data_w-1:0] sent [2*frame_words];
    logic [data_w-1:0] got;
    bit                last;
    send_beat({28'd0, cmd_tag, m});
    foreach (sent[i]) begin
      sent[i] = $random(seed);
      send_beat(sent[i]);
    end
    foreach (sent[i]) begin
      collect_beat(1'b0, got, last);
      check("sm_tdata", got, sent[i]);
      check("sm_tlast", 32'(last), 32'(i == 2*frame_words - 1));
    end
    expect_status(32'd1);
  endtask

  // One zero-extended 16-bit beat per word under random output stalls
  task automatic test_int_frame(input mode_e m);
    logic [data_w-1:0] sent [frame_words];
    logic [data_w-1:0] got;
    bit                last;
    send_beat({28'd0, cmd_tag, m});
    foreach (sent[i]) begin
      sent[i] = $random(seed);
      send_beat(sent[i]);
    end
    foreach (sent[i]) begin
      collect_beat(1'b1, got, last);
      check("sm_tdata", got, {{(data_w-u_w){1'b0}}, sent[i][u_w-1:0]});
      check("sm_tlast", 32'(last), 32'(i == frame_words - 1));
    end
    expect_status(32'd1);
  endtask

  task automatic restart_frame();
    axil_write(status_addr, 32'd1);
    expect_status(32'd0);
    expect_quiet(1, 1'b1);  // Back in command mode
  endtask

  task automatic test_restart();
    axil_write(status_addr, 32'h2);  // Bit 0 clear
    expect_status(32'd1);
    axil_write(12'h004, 32'd1);      // Wrong offset
    expect_status(32'd1);
    restart_frame();
    test_complex_frame(mode_ifft);
  endtask

  initial begin
    seed      = 57;
    awvalid   = 1'b0;
    awaddr    = '0;
    wvalid    = 1'b0;
    wdata     = '0;
    arvalid   = 1'b0;
    araddr    = '0;
    rready    = 1'b0;
    ss_tvalid = 1'b0;
    ss_tdata  = '0;
    ss_tlast  = 1'b0;
    sm_tready = 1'b0;
    @(posedge axi_reset_n);  // Released drive_dly after an edge
    expect_status(32'd0);
    expect_quiet(1, 1'b1);
    test_ignored_beats();
    test_complex_frame(mode_fft);
    restart_frame();
    test_int_frame(mode_intt);
    test_restart();
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+sim
src/fft_buf_pkg.sv
src/ram_if.sv
src/axil_status_regs.sv
src/frame_ctrl.sv
src/stream_in_packer.sv
src/frame_ram.sv
src/stream_out_unpacker.sv
src/fft_buf_top.sv
sim/tb_clk_gen.sv
sim/tb_fft_buf.sv

// ==== Makefile ====
TOOL      = verilator
FLAGS     = --timing
TOP       = tb_fft_buf
FILE_LIST = list.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = SIMULATION PASSED

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(FLAGS) -f $(FILE_LIST) --top-module $(TOP)

sim:
	$(TOOL) --binary $(FLAGS) -f $(FILE_LIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
